/* project.f */
+incdir+verif
source/fetch_pkg.sv
source/pc_ctrl.sv
source/line_fetch.sv
source/inst_buffer.sv
source/fetch_unit.sv
verif/fetch_checker.sv
verif/tb_fetch_unit.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the fetch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_fetch_unit \
    -Mdir obj_dir \
    -f project.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/Vtb_fetch_unit)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test completed successfully" <<< "$output"; then
    exit 0
fi
echo "Pass message not found"
exit 1

/* source/fetch_pkg.sv */
package fetch_pkg;

    // Basic widths
    typedef logic [47:0] addr_t;                // Byte address
    typedef logic [63:0] word_t;                // Bus data word
    typedef logic [18:0] wb_adr_t;              // Word index, address bits 21..3

    // Line geometry
    localparam int LINE_WORDS = 8;              // Bus words per line
    localparam int LINE_BYTES = 64;             // PC step per line

    // Line request from pc_ctrl to line_fetch
    typedef struct packed {
        wb_adr_t idx;                           // First word of the line
        addr_t   base;                          // Byte address of the line
    } fetch_req_t;

    // Wishbone classic, read only
    typedef struct packed {
        logic    cyc;
        logic    stb;
        wb_adr_t adr;
    } wb_req_t;

    typedef struct packed {
        word_t dat;
        logic  ack;
    } wb_rsp_t;

    typedef struct packed {
        logic       valid;
        logic [2:0] slot;                       // Word position in the line
        word_t      dat;
    } fill_t;

    typedef struct packed {
        addr_t       pc;
        logic [31:0] code;
    } inst_t;

endpackage

/* source/fetch_unit.sv */
module fetch_unit (
    input  logic               clock,
    input  logic               reset_n,
    input  fetch_pkg::addr_t   boot_addr,
    input  fetch_pkg::addr_t   interrupt_addr,
    input  fetch_pkg::addr_t   redirect_target,
    input  logic               interrupt_valid,
    input  logic               redirect_valid,
    // Wishbone read port
    output fetch_pkg::wb_req_t wb_req,
    input  fetch_pkg::wb_rsp_t wb_rsp,
    // Instruction port
    output logic               inst_valid,
    input  logic               inst_ready,
    output fetch_pkg::inst_t   inst
);

    logic                  req_valid;
    logic                  req_ready;
    fetch_pkg::fetch_req_t req;
    logic                  can_fetch;
    logic                  clear_ibuffer;
    logic                  fetch_inst;
    logic                  line_done;
    fetch_pkg::addr_t      line_pc;
    fetch_pkg::fill_t      fill;

    // Address side
    pc_ctrl u_pc_ctrl (
        .clock           (clock),
        .reset_n         (reset_n),
        .boot_addr       (boot_addr),
        .interrupt_addr  (interrupt_addr),
        .redirect_target (redirect_target),
        .interrupt_valid (interrupt_valid),
        .redirect_valid  (redirect_valid),
        .fetch_inst      (fetch_inst),
        .line_done       (line_done),
        .can_fetch       (can_fetch),
        .clear_ibuffer   (clear_ibuffer),
        .line_pc         (line_pc),
        .req_ready       (req_ready),
        .req_valid       (req_valid),
        .req             (req)
    );

    // Data side, bus master
    line_fetch u_line_fetch (
        .clock         (clock),
        .reset_n       (reset_n),
        .req_valid     (req_valid),
        .req           (req),
        .req_ready     (req_ready),
        .clear_ibuffer (clear_ibuffer),
        .wb_req        (wb_req),
        .wb_rsp        (wb_rsp),
        .fill          (fill),
        .line_done     (line_done)
    );

    inst_buffer u_inst_buffer (
        .clock         (clock),
        .reset_n       (reset_n),
        .fill          (fill),
        .line_done     (line_done),
        .can_fetch     (can_fetch),
        .clear_ibuffer (clear_ibuffer),
        .line_pc       (line_pc),
        .fetch_inst    (fetch_inst),
        .inst_valid    (inst_valid),
        .inst_ready    (inst_ready),
        .inst          (inst)
    );

endmodule

/* source/inst_buffer.sv */
module inst_buffer (
    input  logic               clock,
    input  logic               reset_n,
    // From line_fetch
    input  fetch_pkg::fill_t   fill,
    input  logic               line_done,
    // From pc_ctrl
    input  logic               can_fetch,
    input  logic               clear_ibuffer,
    input  fetch_pkg::addr_t   line_pc,
    output logic               fetch_inst,
    // Consumer port
    output logic               inst_valid,
    input  logic               inst_ready,
    output fetch_pkg::inst_t   inst
);

    localparam int LAST_INST = 2 * fetch_pkg::LINE_WORDS - 1;  // Sixteen per line

    fetch_pkg::word_t                words [fetch_pkg::LINE_WORDS];
    logic [fetch_pkg::LINE_WORDS-1:0] word_vld;  // One bit per filled word
    logic [3:0]                      rd_ptr;    // Next instruction, half-word granular
    logic                            line_complete;
    logic                            empty;
    logic                            take;
    logic                            last_take;
    fetch_pkg::word_t                cur_word;

    assign empty     = (word_vld == '0) && !line_complete;
    assign fetch_inst = empty & can_fetch;

    // Streams as soon as the addressed word has landed
    assign inst_valid = word_vld[rd_ptr[3:1]] & ~clear_ibuffer;
    assign take       = inst_valid & inst_ready;
    assign last_take  = take && (rd_ptr == 4'(LAST_INST));

    assign cur_word  = words[rd_ptr[3:1]];
    assign inst.pc   = line_pc + fetch_pkg::addr_t'({rd_ptr, 2'b00});
    assign inst.code = rd_ptr[0] ? cur_word[63:32] : cur_word[31:0];  // Low half first

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            word_vld      <= '0;
            rd_ptr        <= '0;
            line_complete <= 1'b0;
        end else if (clear_ibuffer) begin
            // Flush wins over any fill in the same cycle
            word_vld      <= '0;
            rd_ptr        <= '0;
            line_complete <= 1'b0;
        end else begin
            if (fill.valid) begin
                word_vld[fill.slot] <= 1'b1;
            end
            if (line_done) begin
                line_complete <= 1'b1;
            end
            if (take) begin
                rd_ptr <= rd_ptr + 4'd1;        // Wraps to 0 after the last one
            end
            if (last_take) begin
                word_vld      <= '0;            // Drained, next line may be requested
                line_complete <= 1'b0;
            end
        end
    end

    // Word storage
    always_ff @(posedge clock) begin
        if (fill.valid) begin
            words[fill.slot] <= fill.dat;
        end
    end

    // The last word and line_done come together from line_fetch
    a_drain_complete: assert property (@(posedge clock) disable iff (!reset_n)
        last_take |-> line_complete)
        else $error("inst_buffer: line drained before line_done");

endmodule

/* source/line_fetch.sv */
module line_fetch (
    input  logic                  clock,
    input  logic                  reset_n,
    // Line request from pc_ctrl
    input  logic                  req_valid,
    input  fetch_pkg::fetch_req_t req,
    output logic                  req_ready,
    input  logic                  clear_ibuffer,
    // Wishbone master port
    output fetch_pkg::wb_req_t    wb_req,
    input  fetch_pkg::wb_rsp_t    wb_rsp,
    // Returned words
    output fetch_pkg::fill_t      fill,
    output logic                  line_done
);

    logic                busy;                  // Bus cycle in progress
    logic                stale;                 // Line in flight was flushed
    logic [2:0]          cnt;                   // Word counter within the line
    fetch_pkg::wb_adr_t  line_idx;              // Word index of word 0
    logic                ack;
    logic                last_ack;
    logic                fill_valid;
    logic [2:0]          fill_slot;
    fetch_pkg::word_t    fill_dat;

    assign req_ready = ~busy;                   // Only accept when idle
    assign ack       = busy & wb_rsp.ack;
    assign last_ack  = ack && (cnt == 3'(fetch_pkg::LINE_WORDS - 1));

    // Classic cycle, cyc and stb stay up for the whole line
    assign wb_req.cyc = busy;
    assign wb_req.stb = busy;
    assign wb_req.adr = line_idx + fetch_pkg::wb_adr_t'(cnt);

    assign fill.valid = fill_valid;
    assign fill.slot  = fill_slot;
    assign fill.dat   = fill_dat;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy       <= 1'b0;
            stale      <= 1'b0;
            cnt        <= '0;
            fill_valid <= 1'b0;
            line_done  <= 1'b0;
        end else begin
            fill_valid <= 1'b0;
            line_done  <= 1'b0;
            if (!busy) begin
                if (req_valid) begin
                    busy  <= 1'b1;              // stb rises one cycle after handshake
                    cnt   <= '0;
                    stale <= 1'b0;              // New line belongs to the current stream
                end
            end else begin
                if (clear_ibuffer) begin
                    stale <= 1'b1;              // Finish on the bus, drop the data
                end
                if (ack) begin
                    fill_valid <= ~stale & ~clear_ibuffer;
                    cnt        <= cnt + 3'd1;
                    if (last_ack) begin
                        busy      <= 1'b0;
                        line_done <= ~stale & ~clear_ibuffer;
                    end
                end
            end
        end
    end

    // Payload, no reset
    always_ff @(posedge clock) begin
        if (!busy && req_valid) begin
            line_idx <= req.idx;
        end
        if (ack) begin
            fill_slot <= cnt;
            fill_dat  <= wb_rsp.dat;
        end
    end

    // Master holds the strobe and address through wait states
    a_wb_hold: assert property (@(posedge clock) disable iff (!reset_n)
        wb_req.stb && !wb_rsp.ack |=> wb_req.stb && wb_req.cyc && $stable(wb_req.adr))
        else $error("line_fetch: stb or adr dropped before ack");

endmodule

/* source/pc_ctrl.sv */
module pc_ctrl (
    input  logic                 clock,
    input  logic                 reset_n,
    // Address sources
    input  fetch_pkg::addr_t     boot_addr,
    input  fetch_pkg::addr_t     interrupt_addr,
    input  fetch_pkg::addr_t     redirect_target,
    input  logic                 interrupt_valid,
    input  logic                 redirect_valid,
    // Buffer side
    input  logic                 fetch_inst,
    input  logic                 line_done,
    output logic                 can_fetch,
    output logic                 clear_ibuffer,
    output fetch_pkg::addr_t     line_pc,
    // Line request to line_fetch
    input  logic                 req_ready,
    output logic                 req_valid,
    output fetch_pkg::fetch_req_t req
);

    fetch_pkg::addr_t pc;
    logic             fetch_inst_q;             // Previous fetch_inst for edge detect
    logic             fetch_rise;
    logic             flush;                    // Interrupt or redirect this cycle
    logic             accept;                   // Handshake branch actually taken

    assign fetch_rise = fetch_inst & ~fetch_inst_q;
    assign flush      = interrupt_valid | redirect_valid;

    // Mirrors the priority of the state update below
    assign accept = req_valid & req_ready & ~flush & ~fetch_rise;

    // Request is the current pc which is already line aligned
    assign req.idx  = pc[21:3];
    assign req.base = pc;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            fetch_inst_q <= 1'b0;
        end else begin
            fetch_inst_q <= fetch_inst;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pc            <= boot_addr;
            req_valid     <= 1'b0;
            can_fetch     <= 1'b1;              // First line requested right after reset
            clear_ibuffer <= 1'b0;
        end else begin
            clear_ibuffer <= 1'b0;              // One cycle pulse per flush
            if (interrupt_valid) begin
                pc            <= interrupt_addr;  // Interrupt beats redirect
                req_valid     <= 1'b1;
                can_fetch     <= 1'b0;
                clear_ibuffer <= 1'b1;
            end else if (redirect_valid) begin
                pc            <= redirect_target;
                req_valid     <= 1'b1;
                can_fetch     <= 1'b0;
                clear_ibuffer <= 1'b1;
            end else if (fetch_rise) begin
                req_valid <= 1'b1;              // Buffer drained so ask for next line
                can_fetch <= 1'b0;
            end else if (accept) begin
                pc        <= pc + fetch_pkg::addr_t'(fetch_pkg::LINE_BYTES);
                req_valid <= 1'b0;
                can_fetch <= 1'b0;
            end else if (line_done && !clear_ibuffer) begin
                // A line_done seen during the flush pulse belongs to a stale line
                can_fetch <= 1'b1;
            end
        end
    end

    // Base of the line now on the bus tags its instructions
    always_ff @(posedge clock) begin
        if (accept) begin
            line_pc <= req.base;
        end
    end

    // Pending request holds until taken unless a flush moves the pc
    a_req_stable: assert property (@(posedge clock) disable iff (!reset_n)
        req_valid && !req_ready && !flush |=> $stable(req))
        else $error("pc_ctrl: req changed while waiting for req_ready");

endmodule

/* verif/mem_hash.svh */
function automatic fetch_pkg::word_t mem_word(fetch_pkg::wb_adr_t adr);
    logic [31:0] h;
    h = {13'd0, adr} * 32'h9e37_79b1;           // Spread the word index
    h = h ^ (h >> 15);
    h = h * 32'h85eb_ca6b;
    h = h ^ (h >> 13);
    return {~h, h};                             // High half is the complement
endfunction

/* verif/fetch_checker.sv */
module fetch_checker (
    input  logic               clock,
    input  logic               reset_n,
    input  fetch_pkg::addr_t   boot_addr,
    input  fetch_pkg::addr_t   interrupt_addr,
    input  fetch_pkg::addr_t   redirect_target,
    input  logic               interrupt_valid,
    input  logic               redirect_valid,
    input  fetch_pkg::wb_req_t wb_req,
    input  fetch_pkg::wb_rsp_t wb_rsp,
    input  logic               inst_valid,
    input  logic               inst_ready,
    input  fetch_pkg::inst_t   inst,
    output int                 error_count,
    output int                 inst_count
);

    `include "mem_hash.svh"

    fetch_pkg::addr_t   exp_pc;                 // Next pc the stream must deliver
    fetch_pkg::inst_t   held_inst;              // Instruction seen at the last edge
    logic               stalled;                // Valid without ready at the last edge
    logic               flushed;                // Interrupt or redirect at the last edge
    logic               stb_waiting;            // Strobe still waiting for ack
    fetch_pkg::wb_adr_t held_adr;
    fetch_pkg::wb_adr_t last_ack_adr;
    int                 ack_cnt;                // Acks in the current bus cycle
    logic               cyc_q;

    // Half of the memory word that holds this pc, low half first
    function automatic logic [31:0] expected_code(fetch_pkg::addr_t pc);
        fetch_pkg::word_t w;
        w = mem_word(pc[21:3]);
        return pc[2] ? w[63:32] : w[31:0];
    endfunction

    task automatic report_mismatch(string name, logic [63:0] expected, logic [63:0] actual);
        error_count++;
        $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
    endtask

    task automatic report_failure(string what);
        error_count++;
        $display("error at %0t: %s", $time, what);
    endtask

    // Wishbone classic rules, eight consecutive words per cycle
    task automatic check_bus();
        if (wb_req.stb && !wb_req.cyc) begin
            report_failure("stb high without cyc");
        end
        if (stb_waiting) begin
            if (!wb_req.stb) begin
                report_failure("stb dropped before ack");
            end else if (wb_req.adr != held_adr) begin
                report_mismatch("wb_req.adr", 64'(held_adr), 64'(wb_req.adr));
            end
        end
        if (wb_req.cyc && wb_req.stb && wb_rsp.ack) begin
            if (ack_cnt == 0) begin
                if (wb_req.adr[2:0] != 3'd0) begin
                    report_failure("bus cycle does not start on a line boundary");
                end
            end else if (wb_req.adr != last_ack_adr + 19'd1) begin
                report_mismatch("wb_req.adr", 64'(last_ack_adr + 19'd1), 64'(wb_req.adr));
            end
            last_ack_adr = wb_req.adr;
            ack_cnt++;
        end
        if (cyc_q && !wb_req.cyc) begin         // End of a bus cycle
            if (ack_cnt != fetch_pkg::LINE_WORDS) begin
                report_failure($sformatf("bus cycle ended after %0d acks instead of %0d",
                                         ack_cnt, fetch_pkg::LINE_WORDS));
            end
            ack_cnt = 0;
        end
        stb_waiting = wb_req.stb && !wb_rsp.ack;
        held_adr    = wb_req.adr;
        cyc_q       = wb_req.cyc;
    endtask

    // Instruction stream against the reference pc
    task automatic check_stream();
        logic flush_now;
        flush_now = interrupt_valid || redirect_valid;
        if (flushed && inst_valid) begin
            report_mismatch("inst_valid", 64'(1'b0), 64'(inst_valid));
        end
        if (stalled && !flushed) begin          // Held instruction must not move
            if (!inst_valid) begin
                report_failure("inst_valid dropped while the consumer stalled");
            end else begin
                if (inst.pc != held_inst.pc) begin
                    report_mismatch("inst.pc", 64'(held_inst.pc), 64'(inst.pc));
                end
                if (inst.code != held_inst.code) begin
                    report_mismatch("inst.code", 64'(held_inst.code), 64'(inst.code));
                end
            end
        end
        if (inst_valid && inst_ready) begin     // Transfer belongs to the old stream
            if (inst.pc != exp_pc) begin
                report_mismatch("inst.pc", 64'(exp_pc), 64'(inst.pc));
            end
            if (inst.code != expected_code(exp_pc)) begin
                report_mismatch("inst.code", 64'(expected_code(exp_pc)), 64'(inst.code));
            end
            exp_pc = exp_pc + 48'd4;
            inst_count++;
        end
        if (interrupt_valid) begin
            exp_pc = interrupt_addr;            // Interrupt wins over redirect
        end else if (redirect_valid) begin
            exp_pc = redirect_target;
        end
        stalled   = inst_valid && !inst_ready;
        held_inst = inst;
        flushed   = flush_now;
    endtask

    always @(posedge clock) begin
        if (!reset_n) begin
            exp_pc      = boot_addr;            // First instruction comes from boot
            stalled     = 1'b0;
            flushed     = 1'b0;
            stb_waiting = 1'b0;
            ack_cnt     = 0;
            cyc_q       = 1'b0;
            inst_count  = 0;
        end else begin
            check_bus();
            check_stream();
        end
    end

endmodule

/* verif/tb_fetch_unit.sv */
module tb_fetch_unit;

    localparam int               NUM_INSTS      = 3000;     // Accepted instructions per run
    localparam int               TIMEOUT_CYCLES = NUM_INSTS * 40;
    localparam int               RESET_CYCLES   = 10;
    localparam fetch_pkg::addr_t BOOT_ADDR      = 48'h0000_4000_0100;

    logic               clock;
    logic               reset_n;
    fetch_pkg::addr_t   boot_addr;
    fetch_pkg::addr_t   interrupt_addr;
    fetch_pkg::addr_t   redirect_target;
    logic               interrupt_valid;
    logic               redirect_valid;
    logic               inst_ready;
    fetch_pkg::wb_req_t wb_req;
    fetch_pkg::wb_rsp_t wb_rsp;
    logic               inst_valid;
    fetch_pkg::inst_t   inst;
    int                 error_count;
    int                 inst_count;
    logic [31:0]        rng_state;              // xorshift state
    logic               ack_pending;            // Memory is counting wait states
    int                 wait_left;

    `include "mem_hash.svh"

    fetch_unit DUT (
        .clock           (clock),
        .reset_n         (reset_n),
        .boot_addr       (boot_addr),
        .interrupt_addr  (interrupt_addr),
        .redirect_target (redirect_target),
        .interrupt_valid (interrupt_valid),
        .redirect_valid  (redirect_valid),
        .wb_req          (wb_req),
        .wb_rsp          (wb_rsp),
        .inst_valid      (inst_valid),
        .inst_ready      (inst_ready),
        .inst            (inst)
    );

    fetch_checker u_checker (
        .clock           (clock),
        .reset_n         (reset_n),
        .boot_addr       (boot_addr),
        .interrupt_addr  (interrupt_addr),
        .redirect_target (redirect_target),
        .interrupt_valid (interrupt_valid),
        .redirect_valid  (redirect_valid),
        .wb_req          (wb_req),
        .wb_rsp          (wb_rsp),
        .inst_valid      (inst_valid),
        .inst_ready      (inst_ready),
        .inst            (inst),
        .error_count     (error_count),
        .inst_count      (inst_count)
    );

    function automatic logic [31:0] rand_next();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic fetch_pkg::addr_t rand_line_addr();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = rand_next();
        lo = rand_next();
        return {hi[15:0], lo[31:6], 6'd0};      // 64-byte aligned
    endfunction

    // Consumer readiness plus occasional flushes
    task automatic drive_consumer_and_flush();
        inst_ready      = (rand_next() % 32'd100) < 32'd70;
        redirect_valid  = 1'b0;
        interrupt_valid = 1'b0;
        if (rand_next() % 32'd60 == 32'd0) begin
            redirect_valid  = 1'b1;
            redirect_target = rand_line_addr();
        end
        if (rand_next() % 32'd150 == 32'd0) begin
            interrupt_valid = 1'b1;
            interrupt_addr  = rand_line_addr();
            if (rand_next() % 32'd3 == 32'd0) begin
                redirect_valid  = 1'b1;         // Same cycle as the interrupt
                redirect_target = rand_line_addr();
            end
        end
    endtask

    // Wishbone slave with 0 to 3 wait states per word
    task automatic drive_memory();
        logic [31:0] r;
        wb_rsp.ack = 1'b0;
        wb_rsp.dat = '0;
        if (wb_req.stb) begin
            if (!ack_pending) begin
                r           = rand_next();
                wait_left   = int'(r[1:0]);
                ack_pending = 1'b1;
            end
            if (wait_left == 0) begin
                wb_rsp.ack  = 1'b1;
                wb_rsp.dat  = mem_word(wb_req.adr);
                ack_pending = 1'b0;             // Next address gets new wait states
            end else begin
                wait_left--;
            end
        end else begin
            ack_pending = 1'b0;
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial begin
        rng_state       = 32'h6a67;
        reset_n         = 1'b0;
        boot_addr       = BOOT_ADDR;
        interrupt_addr  = '0;
        redirect_target = '0;
        interrupt_valid = 1'b0;
        redirect_valid  = 1'b0;
        inst_ready      = 1'b0;
        wb_rsp          = '0;
        ack_pending     = 1'b0;
        wait_left       = 0;
        repeat (RESET_CYCLES) @(posedge clock);
        #2;
        reset_n = 1'b1;
        forever begin
            @(posedge clock);
            #2;                                 // Away from the sampling edge
            drive_consumer_and_flush();
            drive_memory();
        end
    end

    initial begin
        wait (inst_count >= NUM_INSTS);
        @(posedge clock);
        #1;
        $display("Instructions checked: %0d, errors: %0d", inst_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog, generous bound per instruction
    initial begin
        repeat (RESET_CYCLES + TIMEOUT_CYCLES) @(posedge clock);
        $display("Timeout after %0d cycles with %0d of %0d instructions accepted",
                 TIMEOUT_CYCLES, inst_count, NUM_INSTS);
        $display("Test failed");
        $finish;
    end

endmodule
